// File: verilog/trace_pkg.sv
package trace_pkg;

    // one beat from the input FIFO
    localparam int unsigned beat_width = 64;

    // every unit length is a multiple of this many bits
    localparam int unsigned align_width = 8;

    // largest logging unit
    localparam int unsigned unit_width = 192;

    // length field at the bottom of every unit, counted in bits
    localparam int unsigned len_width = 8;

    // alignment units per beat
    localparam int unsigned beat_units = beat_width / align_width;

    // beats needed for the largest unit
    localparam int unsigned unit_beats = (unit_width + beat_width - 1) / beat_width;

    // log2 of the alignment and of the beat size
    // used to turn bit counts into unit and beat counts
    localparam int unsigned align_shift = $clog2(align_width);
    localparam int unsigned beat_shift = $clog2(beat_width);

    typedef logic [beat_width-1:0] beat_t;

    typedef logic [unit_width-1:0] unit_t;

    // length in alignment units, i.e. the length field without its low zero bits
    typedef logic [len_width-align_shift-1:0] unit_len_t;

    // alignment unit index inside one beat
    typedef logic [beat_shift-align_shift-1:0] beat_off_t;

    // trace size in bits
    typedef logic [63:0] replay_bits_t;

    // one segment from the LO half to the assembler
    // len is only meaningful on the first segment of a unit
    typedef struct packed {
        beat_t     data;
        unit_len_t len;
    } seg_t;

endpackage

// File: verilog/fifo_reader.sv
`timescale 1ns/100ps

module fifo_reader (
    input  logic                    clk,
    input  logic                    sync_rst_n,
    input  trace_pkg::beat_t        in_data,
    input  logic                    in_empty,
    output logic                    in_rd_en,
    input  logic                    out_almfull,
    input  trace_pkg::replay_bits_t replay_bits,
    input  logic                    hi_lo_shift,
    output logic                    hi_full,
    output trace_pkg::beat_t        hi_data
);

    typedef enum logic {
        hi_empty_st,
        hi_full_st
    } hi_state_t;

    // counts beats written into HI, padding included
    typedef logic [63-trace_pkg::beat_shift:0] beat_cnt_t;

    hi_state_t               hi_state;
    hi_state_t               hi_state_next;
    logic                    hi_free;
    logic                    hi_pad;
    logic                    hi_load;
    trace_pkg::replay_bits_t bits_round;
    beat_cnt_t               beats_total;
    beat_cnt_t               beat_cnt;

    assign hi_full = (hi_state == hi_full_st);

    // HI can take a beat when empty or when its beat moves to LO this cycle
    assign hi_free = !hi_full || hi_lo_shift;

    // almfull holds reads back so units already in flight still fit downstream
    assign in_rd_en = !in_empty && !out_almfull && hi_free;

    // beats holding the whole trace, replay_bits rounded up
    assign bits_round = replay_bits + trace_pkg::replay_bits_t'(trace_pkg::beat_width - 1);
    assign beats_total = bits_round[63:trace_pkg::beat_shift];

    // one zero beat after the last trace beat flushes the final unit out of LO
    // beat_cnt passes beats_total right after, so this fires once
    assign hi_pad = (beat_cnt != '0) && (beat_cnt == beats_total) && hi_free;

    assign hi_load = in_rd_en || hi_pad;

    always_comb begin
        hi_state_next = hi_state;
        case (hi_state)
            hi_empty_st: begin
                if (hi_load) begin
                    hi_state_next = hi_full_st;
                end
            end
            default: begin
                // shift without refill empties HI, shift with refill keeps it full
                if (hi_lo_shift && !hi_load) begin
                    hi_state_next = hi_empty_st;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            hi_state <= hi_empty_st;
            beat_cnt <= '0;
        end else begin
            hi_state <= hi_state_next;
            if (hi_load) begin
                beat_cnt <= beat_cnt + beat_cnt_t'(1);
            end
        end
    end

    // HI beat register, a real read wins over padding
    always_ff @(posedge clk) begin
        if (in_rd_en) begin
            hi_data <= in_data;
        end else if (hi_pad) begin
            hi_data <= '0;
        end
    end

endmodule

// File: verilog/lo_aligner.sv
`timescale 1ns/100ps

module lo_aligner (
    input  logic                 clk,
    input  logic                 sync_rst_n,
    input  logic                 hi_full,
    input  trace_pkg::beat_t     hi_data,
    output logic                 hi_lo_shift,
    input  logic                 replay_done,
    output logic                 seg_fire,
    output trace_pkg::unit_len_t seg_units,
    output logic                 seg_valid,
    output trace_pkg::seg_t      seg
);

    // empty: nothing in LO yet
    // header: a unit header sits at lo_off
    // body: the rest of a unit sits at lo_off, its length is in remain_reg
    typedef enum logic [1:0] {
        lo_empty_st,
        lo_header_st,
        lo_body_st
    } lo_state_t;

    // offset plus remaining length, one bit wider than the length
    typedef logic [trace_pkg::len_width-trace_pkg::align_shift:0] span_t;

    lo_state_t            lo_state;
    lo_state_t            lo_state_next;
    trace_pkg::beat_t     lo_data;
    trace_pkg::beat_off_t lo_off;
    trace_pkg::unit_len_t remain_reg;
    trace_pkg::unit_len_t remain_len;
    trace_pkg::beat_t     seg_data;
    logic                 lo_empty;
    logic                 lo_out;
    logic                 lo_exhaust;
    logic                 lo_last;

    assign lo_empty = (lo_state == lo_empty_st);

    // one beat's worth of units starting at lo_off, spanning LO and HI
    assign seg_data = trace_pkg::beat_t'({hi_data, lo_data} >> (lo_off * trace_pkg::align_width));

    // remaining length of the current unit
    // header state decodes it straight from the length field
    always_comb begin
        case (lo_state)
            lo_header_st: begin
                remain_len = seg_data[trace_pkg::len_width-1:trace_pkg::align_shift];
            end
            lo_body_st: begin
                remain_len = remain_reg;
            end
            default: begin
                remain_len = '0;
            end
        endcase
    end

    // segments only leave while HI holds data, so the span across LO and HI is contiguous
    assign lo_out = hi_full && !lo_empty;

    // this segment uses LO up to its top unit
    assign lo_exhaust = (span_t'(remain_len) + span_t'(lo_off))
                        >= span_t'(trace_pkg::beat_units);

    // the rest of the unit fits in this segment
    assign lo_last = (remain_len <= trace_pkg::unit_len_t'(trace_pkg::beat_units));

    assign hi_lo_shift = hi_full && (lo_empty || (lo_out && lo_exhaust));

    // trace units handed over by this segment
    assign seg_fire = lo_out;
    assign seg_units = lo_last ? remain_len : trace_pkg::unit_len_t'(trace_pkg::beat_units);

    always_comb begin
        lo_state_next = lo_state;
        case (lo_state)
            lo_empty_st: begin
                if (hi_lo_shift) begin
                    lo_state_next = lo_header_st;
                end
            end
            default: begin
                // a finished unit means the next unit's header is at the new offset
                if (lo_out) begin
                    lo_state_next = lo_last ? lo_header_st : lo_body_st;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            lo_state <= lo_empty_st;
            lo_off   <= '0;
        end else begin
            lo_state <= lo_state_next;
            if (lo_out && lo_last) begin
                // wraps past the beat end exactly when HI moves down
                lo_off <= lo_off + trace_pkg::beat_off_t'(remain_len);
            end
        end
    end

    // a full beat went out, the body carries on at the same offset
    always_ff @(posedge clk) begin
        if (lo_out && !lo_last) begin
            remain_reg <= remain_len - trace_pkg::unit_len_t'(trace_pkg::beat_units);
        end
    end

    always_ff @(posedge clk) begin
        if (hi_lo_shift) begin
            lo_data <= hi_data;
        end
    end

    // registered hand-off to the assembler
    // trailing padding after the last trace unit is held back
    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            seg_valid <= 1'b0;
        end else begin
            seg_valid <= lo_out && !replay_done;
        end
    end

    always_ff @(posedge clk) begin
        seg.data <= seg_data;
        seg.len  <= remain_len;
    end

endmodule

// File: verilog/replay_counter.sv
`timescale 1ns/100ps

module replay_counter (
    input  logic                    clk,
    input  logic                    sync_rst_n,
    input  logic                    seg_fire,
    input  trace_pkg::unit_len_t    seg_units,
    input  trace_pkg::replay_bits_t replay_bits,
    output logic                    replay_done,
    output trace_pkg::replay_bits_t rt_replay_bits
);

    // trace size in alignment units
    typedef logic [63-trace_pkg::align_shift:0] unit_cnt_t;

    unit_cnt_t            units_total;
    unit_cnt_t            unit_cnt;
    trace_pkg::unit_len_t unit_add;

    assign units_total = replay_bits[63:trace_pkg::align_shift];

    // pending addition counted too, so done rises the cycle after the last segment
    assign replay_done = (units_total == unit_cnt + unit_cnt_t'(unit_add));

    // progress in bits, low bits always zero
    assign rt_replay_bits = {unit_cnt, {trace_pkg::align_shift{1'b0}}};

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            unit_cnt <= '0;
            unit_add <= '0;
        end else begin
            unit_cnt <= unit_cnt + unit_cnt_t'(unit_add);
            // padding after done adds nothing
            unit_add <= (seg_fire && !replay_done) ? seg_units : '0;
        end
    end

endmodule

// File: verilog/unit_assembler.sv
`timescale 1ns/100ps

module unit_assembler (
    input  logic             clk,
    input  logic             sync_rst_n,
    input  logic             seg_valid,
    input  trace_pkg::seg_t  seg,
    output trace_pkg::unit_t unit_data,
    output logic             unit_wr_en
);

    // wait_header: idle, next segment starts a unit
    // wait_body: header taken, more beats to come
    // done: whole unit held, written out this cycle
    typedef enum logic [1:0] {
        asm_wait_header_st,
        asm_wait_body_st,
        asm_done_st
    } asm_state_t;

    // beats already collected for the current unit
    typedef logic [$clog2(trace_pkg::unit_beats+1)-1:0] beat_idx_t;

    // units covered so far, wide enough for a full unit
    typedef logic [trace_pkg::len_width-trace_pkg::align_shift:0] span_t;

    asm_state_t                                   asm_state;
    asm_state_t                                   asm_state_next;
    trace_pkg::unit_len_t                         unit_len;
    beat_idx_t                                    beat_cnt;
    trace_pkg::beat_t [trace_pkg::unit_beats-1:0] unit_buf;
    span_t                                        covered_units;
    logic                                         head_short;
    logic                                         body_last;

    // incoming header belongs to a unit of one beat or less
    assign head_short = (seg.len <= trace_pkg::unit_len_t'(trace_pkg::beat_units));

    // units covered once the incoming body beat is stored
    assign covered_units = (span_t'(beat_cnt) + span_t'(1)) * span_t'(trace_pkg::beat_units);
    assign body_last = (span_t'(unit_len) <= covered_units);

    always_comb begin
        asm_state_next = asm_state;
        case (asm_state)
            asm_wait_header_st: begin
                if (seg_valid) begin
                    asm_state_next = head_short ? asm_done_st : asm_wait_body_st;
                end
            end
            asm_wait_body_st: begin
                if (seg_valid && body_last) begin
                    asm_state_next = asm_done_st;
                end
            end
            default: begin
                // output never stalls, so a header here starts the next unit at once
                if (seg_valid) begin
                    asm_state_next = head_short ? asm_done_st : asm_wait_body_st;
                end else begin
                    asm_state_next = asm_wait_header_st;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!sync_rst_n) begin
            asm_state <= asm_wait_header_st;
            unit_len  <= '0;
            beat_cnt  <= '0;
        end else begin
            asm_state <= asm_state_next;
            if (asm_state == asm_wait_body_st) begin
                if (seg_valid) begin
                    beat_cnt <= beat_cnt + beat_idx_t'(1);
                end
            end else if (seg_valid) begin
                unit_len <= seg.len;
                beat_cnt <= beat_idx_t'(1);
            end
        end
    end

    // header lands in beat 0, body beats follow in order
    always_ff @(posedge clk) begin
        if (seg_valid) begin
            if (asm_state == asm_wait_body_st) begin
                unit_buf[beat_cnt] <= seg.data;
            end else begin
                unit_buf[0] <= seg.data;
            end
        end
    end

    assign unit_wr_en = (asm_state == asm_done_st);
    assign unit_data = unit_buf;

endmodule

// File: verilog/trace_parser_top.sv
`timescale 1ns/100ps

module trace_parser_top (
    input  logic                    clk,
    input  logic                    sync_rst_n,
    input  trace_pkg::beat_t        in_data,
    input  logic                    in_empty,
    output logic                    in_rd_en,
    output trace_pkg::unit_t        unit_data,
    output logic                    unit_wr_en,
    input  logic                    out_almfull,
    input  trace_pkg::replay_bits_t replay_bits,
    output trace_pkg::replay_bits_t rt_replay_bits
);

    // HI half to LO half
    logic                 hi_full;
    trace_pkg::beat_t     hi_data;
    logic                 hi_lo_shift;

    // LO half to the progress counter and back
    logic                 seg_fire;
    trace_pkg::unit_len_t seg_units;
    logic                 replay_done;

    // LO half to the assembler
    logic                 seg_valid;
    trace_pkg::seg_t      seg;

    fifo_reader fifo_reader_i (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .in_data     (in_data),
        .in_empty    (in_empty),
        .in_rd_en    (in_rd_en),
        .out_almfull (out_almfull),
        .replay_bits (replay_bits),
        .hi_lo_shift (hi_lo_shift),
        .hi_full     (hi_full),
        .hi_data     (hi_data)
    );

    lo_aligner lo_aligner_i (
        .clk         (clk),
        .sync_rst_n  (sync_rst_n),
        .hi_full     (hi_full),
        .hi_data     (hi_data),
        .hi_lo_shift (hi_lo_shift),
        .replay_done (replay_done),
        .seg_fire    (seg_fire),
        .seg_units   (seg_units),
        .seg_valid   (seg_valid),
        .seg         (seg)
    );

    replay_counter replay_counter_i (
        .clk            (clk),
        .sync_rst_n     (sync_rst_n),
        .seg_fire       (seg_fire),
        .seg_units      (seg_units),
        .replay_bits    (replay_bits),
        .replay_done    (replay_done),
        .rt_replay_bits (rt_replay_bits)
    );

    unit_assembler unit_assembler_i (
        .clk        (clk),
        .sync_rst_n (sync_rst_n),
        .seg_valid  (seg_valid),
        .seg        (seg),
        .unit_data  (unit_data),
        .unit_wr_en (unit_wr_en)
    );

endmodule

// File: tests/tb_trace_model.svh
`ifndef tb_trace_model_svh
`define tb_trace_model_svh

// stimulus beats for the row being run, front is what in_data shows
trace_pkg::beat_t beat_q[$];

// expected units and their lengths in bits, in trace order
trace_pkg::unit_t exp_unit_q[$];
int unsigned      exp_len_q[$];

// beats that hold a row's trace, tail zero-filled
function automatic int unsigned beats_for_row(input int row);
    int unsigned bits;
    bits = 0;
    for (int u = 0; u < max_units; u++) begin
        bits += row_lens[row][u];
    end
    return (bits + trace_pkg::beat_width - 1) / trace_pkg::beat_width;
endfunction

// header carries the length, every other byte is random
// units are packed back to back as a byte stream, then cut into beats
task automatic build_row(input int row, output trace_pkg::replay_bits_t bits);
    logic [7:0]       byte_q[$];
    trace_pkg::unit_t unit;
    trace_pkg::beat_t beat;
    int unsigned      len;
    int unsigned      rnd;
    beat_q.delete();
    exp_unit_q.delete();
    exp_len_q.delete();
    bits = '0;
    for (int u = 0; u < max_units; u++) begin
        len = row_lens[row][u];
        if (len != 0) begin
            unit = '0;
            unit[trace_pkg::len_width-1:0] = len[7:0];
            for (int b = 1; b < len / trace_pkg::align_width; b++) begin
                rnd = $random(seed);
                unit[b*trace_pkg::align_width +: trace_pkg::align_width] = rnd[7:0];
            end
            for (int b = 0; b < len / trace_pkg::align_width; b++) begin
                byte_q.push_back(unit[b*trace_pkg::align_width +: trace_pkg::align_width]);
            end
            exp_unit_q.push_back(unit);
            exp_len_q.push_back(len);
            bits += trace_pkg::replay_bits_t'(len);
        end
    end
    // last beat padded with zero bytes
    while (byte_q.size() % trace_pkg::beat_units != 0) begin
        byte_q.push_back(8'h00);
    end
    for (int i = 0; i < byte_q.size(); i += trace_pkg::beat_units) begin
        for (int b = 0; b < trace_pkg::beat_units; b++) begin
            beat[b*trace_pkg::align_width +: trace_pkg::align_width] = byte_q[i+b];
        end
        beat_q.push_back(beat);
    end
endtask

`endif

// File: tests/tb_trace_parser.sv
`timescale 1ns/100ps

module tb_trace_parser;

    localparam int num_rows = 6;
    localparam int max_units = 12;
    localparam int reset_cycles = 10;
    // quiet cycles after the last unit of a row, extra writes show up here
    localparam int drain_cycles = 20;
    localparam int cycles_per_beat = 40;

    // unit lengths in bits, zero ends the list
    localparam int unsigned row_lens [num_rows][max_units] = '{
        '{40, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{64, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        '{192, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0},
        // 9 and 17 bytes, so the start offset walks through 0..7
        '{72, 136, 72, 136, 72, 136, 72, 136, 0, 0, 0, 0},
        '{24, 64, 8, 192, 56, 16, 104, 48, 160, 32, 88, 120},
        '{8, 192, 184, 16, 96, 128, 8, 8, 40, 176, 0, 0}
    };

    // chance in percent of in_empty and out_almfull per cycle
    localparam int unsigned row_empty_pct [num_rows] = '{0, 20, 0, 0, 25, 50};
    localparam int unsigned row_almfull_pct [num_rows] = '{0, 0, 0, 0, 25, 40};

    logic                    clk = 1'b0;
    logic                    sync_rst_n;
    trace_pkg::beat_t        in_data;
    logic                    in_empty;
    logic                    in_rd_en;
    trace_pkg::unit_t        unit_data;
    logic                    unit_wr_en;
    logic                    out_almfull;
    trace_pkg::replay_bits_t replay_bits;
    trace_pkg::replay_bits_t rt_replay_bits;

    integer      seed = 32'h242b_ec83;

    `include "tb_trace_model.svh"

    trace_parser_top trace_parser_top_i (
        .clk            (clk),
        .sync_rst_n     (sync_rst_n),
        .in_data        (in_data),
        .in_empty       (in_empty),
        .in_rd_en       (in_rd_en),
        .unit_data      (unit_data),
        .unit_wr_en     (unit_wr_en),
        .out_almfull    (out_almfull),
        .replay_bits    (replay_bits),
        .rt_replay_bits (rt_replay_bits)
    );

    always #5 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic logic chance(input int unsigned pct);
        int unsigned rnd;
        rnd = $random(seed);
        return (rnd % 100) < pct;
    endfunction

    // only the unit's own length is defined, bits above it are don't care
    task automatic check_unit(input trace_pkg::unit_t got, input trace_pkg::unit_t exp,
                              input int unsigned len_bits);
        trace_pkg::unit_t mask;
        mask = ~(trace_pkg::unit_t'('1) << len_bits);
        if ((got & mask) !== (exp & mask)) begin
            fail_run($sformatf("Mismatch at time %0t: %0d-bit unit expected %h got %h",
                               $time, len_bits, exp & mask, got & mask));
        end
    endtask

    task automatic check_bits(input trace_pkg::replay_bits_t got,
                              input trace_pkg::replay_bits_t exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at time %0t: %s expected %0d got %0d",
                               $time, what, exp, got));
        end
    endtask

    task automatic run_row(input int row);
        trace_pkg::replay_bits_t bits;
        trace_pkg::unit_t        exp_unit;
        int unsigned             exp_len;
        int                      idle;
        logic                    took;
        build_row(row, bits);
        @(negedge clk);
        sync_rst_n = 1'b0;
        in_empty = 1'b1;
        in_data = '0;
        out_almfull = 1'b0;
        replay_bits = bits;
        repeat (reset_cycles) @(negedge clk);
        sync_rst_n = 1'b1;
        took = 1'b0;
        idle = 0;
        while (idle < drain_cycles) begin
            // beat taken at the last rising edge leaves the show-ahead FIFO
            if (took) begin
                void'(beat_q.pop_front());
            end
            in_empty = (beat_q.size() == 0) || chance(row_empty_pct[row]);
            in_data = (beat_q.size() != 0) ? beat_q[0] : '0;
            out_almfull = chance(row_almfull_pct[row]);
            // outputs settle well before the next rising edge
            #1;
            took = in_rd_en;
            if (in_rd_en && (in_empty || out_almfull)) begin
                fail_run("in_rd_en was high while in_empty or out_almfull was high");
            end
            if (unit_wr_en) begin
                if (exp_unit_q.size() == 0) begin
                    fail_run("a unit was written after the last unit of the row");
                end
                exp_unit = exp_unit_q.pop_front();
                exp_len = exp_len_q.pop_front();
                check_unit(unit_data, exp_unit, exp_len);
            end
            if (exp_unit_q.size() == 0) begin
                idle++;
            end
            @(negedge clk);
        end
        check_bits(rt_replay_bits, bits, "rt_replay_bits");
    endtask

    initial begin
        sync_rst_n = 1'b0;
        in_data = '0;
        in_empty = 1'b1;
        out_almfull = 1'b0;
        replay_bits = '0;
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        $display("TEST OK");
        $finish;
    end

    // budget per beat plus reset and drain of every row
    initial begin
        int unsigned limit;
        limit = 0;
        for (int r = 0; r < num_rows; r++) begin
            limit += beats_for_row(r) * cycles_per_beat + reset_cycles + drain_cycles + 2;
        end
        repeat (limit) @(posedge clk);
        fail_run($sformatf("timeout: the run did not finish within %0d cycles", limit));
    end

endmodule

// File: project.f
verilog/trace_pkg.sv
verilog/fifo_reader.sv
verilog/lo_aligner.sv
verilog/replay_counter.sv
verilog/unit_assembler.sv
verilog/trace_parser_top.sv
tests/tb_trace_parser.sv
+incdir+tests

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_trace_parser -f project.f \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_trace_parser > sim.log 2>&1 || true
cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || grep -q "TEST OK" sim.log
